//--- verilog/cpuPkg.sv
package cpuPkg;

  // Datapath and register index widths
  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  // Memory depths in words
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;

  // Stores to this byte address go out on the I/O strobe
  localparam logic [XLEN-1:0] IO_ADDR = 32'h0000_0400;

  // Extra cycles every data access spends before success
  localparam int DMEM_WAIT = 2;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcodeT;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } aluOpT;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_WAIT,
    MEM_DONE
  } memStateT;

endpackage

//--- verilog/Alu.sv
`timescale 1ns/10ps

module Alu import cpuPkg::*; (
  input  opcodeT          opcode,
  input  logic [2:0]      funct3,
  input  logic [6:0]      funct7,
  input  logic [XLEN-1:0] operandA,
  input  logic [XLEN-1:0] operandB,
  output logic [XLEN-1:0] result,
  output logic            zero
);

  aluOpT op;

  // ALU control
  always_comb begin
    op = ALU_ADD;
    case (opcode)
      OP_REG, OP_IMM: begin
        case (funct3)
          3'b000: op = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b010: op = ALU_SLT;
          3'b100: op = ALU_XOR;
          3'b110: op = ALU_OR;
          3'b111: op = ALU_AND;
          default: op = ALU_ADD;
        endcase
      end
      OP_LUI: op = ALU_PASS_B;
      OP_BRANCH: op = ALU_SUB;
      default: op = ALU_ADD;
    endcase
  end

  always_comb begin
    case (op)
      ALU_SUB: result = operandA - operandB;
      ALU_AND: result = operandA & operandB;
      ALU_OR: result = operandA | operandB;
      ALU_XOR: result = operandA ^ operandB;
      ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(operandA) < $signed(operandB)};
      ALU_PASS_B: result = operandB;
      default: result = operandA + operandB;
    endcase
  end

  // Branch compare uses the SUB result
  assign zero = (result == '0);

endmodule

//--- verilog/Decoder.sv
`timescale 1ns/10ps

module Decoder import cpuPkg::*; (
  input  logic [XLEN-1:0] instruction,
  output aluOpT           aluOp,
  output logic            aluSrc,
  output logic            memRead,
  output logic            memWrite,
  output logic            memToReg,
  output logic            regWrite,
  output logic            branch,
  output logic            branchNotEqual,
  output logic            jump,
  output logic [XLEN-1:0] immediate
);

  logic [XLEN-1:0] immI, immS, immB, immU, immJ;

  assign immI = {{20{instruction[31]}}, instruction[31:20]};
  assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign immB = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                 instruction[11:8], 1'b0};
  assign immU = {instruction[31:12], 12'b0};
  assign immJ = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                 instruction[30:21], 1'b0};

  always_comb begin
    // Anything unrecognized falls through as a bubble
    aluOp = ALU_ADD;
    aluSrc = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    branch = 1'b0;
    branchNotEqual = 1'b0;
    jump = 1'b0;
    immediate = '0;
    case (instruction[6:0])
      OP_LUI: begin
        aluOp = ALU_PASS_B;
        aluSrc = 1'b1;
        regWrite = 1'b1;
        immediate = immU;
      end
      OP_IMM: begin
        aluSrc = 1'b1;
        regWrite = 1'b1;
        immediate = immI;
      end
      OP_REG: begin
        regWrite = 1'b1;
      end
      OP_LOAD: begin
        aluSrc = 1'b1;
        memRead = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        immediate = immI;
      end
      OP_STORE: begin
        aluSrc = 1'b1;
        memWrite = 1'b1;
        immediate = immS;
      end
      OP_BRANCH: begin
        aluOp = ALU_SUB;
        branch = 1'b1;
        // funct3 LSB tells BNE from BEQ
        branchNotEqual = instruction[12];
        immediate = immB;
      end
      OP_JAL: begin
        aluSrc = 1'b1;
        regWrite = 1'b1;
        jump = 1'b1;
        immediate = immJ;
      end
      default: begin
        aluOp = ALU_ADD;
      end
    endcase
  end

endmodule

//--- verilog/RegisterFile.sv
`timescale 1ns/10ps

module RegisterFile import cpuPkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic [REG_ADDR_W-1:0] readIndexA,
  input  logic [REG_ADDR_W-1:0] readIndexB,
  input  logic [REG_ADDR_W-1:0] writeIndex,
  input  logic [XLEN-1:0]       writeData,
  input  logic                  writeEnable,
  output logic [XLEN-1:0]       readDataA,
  output logic [XLEN-1:0]       readDataB
);

  logic [XLEN-1:0] regs [2**REG_ADDR_W];

  function automatic logic [XLEN-1:0] readRegister(input logic [REG_ADDR_W-1:0] index);
    if (index == '0) return '0;
    // Same-cycle writeback goes straight to the read port
    if (writeEnable && writeIndex == index) return writeData;
    return regs[index];
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeIndex != '0) begin
      regs[writeIndex] <= writeData;
    end
  end

  always_comb begin
    readDataA = readRegister(readIndexA);
    readDataB = readRegister(readIndexB);
  end

endmodule

//--- verilog/HazardUnit.sv
`timescale 1ns/10ps

module HazardUnit import cpuPkg::*; (
  input  logic [REG_ADDR_W-1:0] idReadIndexA,
  input  logic [REG_ADDR_W-1:0] idReadIndexB,
  input  logic [REG_ADDR_W-1:0] exReadIndexA,
  input  logic [REG_ADDR_W-1:0] exReadIndexB,
  input  logic [REG_ADDR_W-1:0] exWriteIndex,
  input  logic                  exMemRead,
  input  logic [REG_ADDR_W-1:0] memWriteIndex,
  input  logic                  memRegWrite,
  input  logic [REG_ADDR_W-1:0] wbWriteIndex,
  input  logic                  wbRegWrite,
  output logic                  stall,
  output logic [1:0]            fwdA,
  output logic [1:0]            fwdB
);

  // 2 picks the memory-stage result, 1 the writeback data
  function automatic logic [1:0] forwardSelect(input logic [REG_ADDR_W-1:0] readIndex);
    if (readIndex == '0) return 2'd0;
    if (memRegWrite && memWriteIndex == readIndex) return 2'd2;
    if (wbRegWrite && wbWriteIndex == readIndex) return 2'd1;
    return 2'd0;
  endfunction

  // Load in EX feeding the instruction in ID
  always_comb begin
    stall = 1'b0;
    if (exMemRead && exWriteIndex != '0) begin
      stall = (exWriteIndex == idReadIndexA) || (exWriteIndex == idReadIndexB);
    end
  end

  always_comb begin
    fwdA = forwardSelect(exReadIndexA);
    fwdB = forwardSelect(exReadIndexB);
  end

endmodule

//--- verilog/Mmu.sv
`timescale 1ns/10ps

module Mmu import cpuPkg::*; (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          loadEnable,
  input  logic [$clog2(IMEM_WORDS)-1:0] loadAddress,
  input  logic [XLEN-1:0]               loadData,
  input  logic [XLEN-1:0]               instrAddress,
  input  logic                          memRead,
  input  logic                          memWrite,
  input  logic [XLEN-1:0]               dataAddress,
  input  logic [XLEN-1:0]               dataIn,
  output logic [XLEN-1:0]               instruction,
  output logic [XLEN-1:0]               dataOut,
  output logic                          dataSuccess,
  output logic                          ioWrite,
  output logic [XLEN-1:0]               ioData
);

  logic [XLEN-1:0] imem [IMEM_WORDS];
  logic [XLEN-1:0] dmem [DMEM_WORDS];
  logic [$clog2(DMEM_WORDS)-1:0] dataIndex;
  logic [$clog2(DMEM_WAIT)-1:0] waitCount;
  logic [XLEN-1:0] readData;
  logic access, ioSelect;
  memStateT state;

  // Program load only happens with reset held
  always_ff @(posedge clk) begin
    if (!rstN && loadEnable) begin
      imem[loadAddress] <= loadData;
    end
  end

  assign instruction = imem[instrAddress[$clog2(IMEM_WORDS)+1:2]];

  assign access = memRead || memWrite;
  assign ioSelect = (dataAddress == IO_ADDR);
  assign dataIndex = dataAddress[$clog2(DMEM_WORDS)+1:2];

  // Wait states are the IDLE cycle plus the WAIT cycles
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= MEM_IDLE;
      waitCount <= '0;
    end else begin
      case (state)
        MEM_IDLE: begin
          if (access) begin
            state <= MEM_WAIT;
            waitCount <= $bits(waitCount)'(DMEM_WAIT - 2);
          end
        end
        MEM_WAIT: begin
          if (waitCount == '0) begin
            state <= MEM_DONE;
          end else begin
            waitCount <= waitCount - 1'b1;
          end
        end
        MEM_DONE: state <= MEM_IDLE;
        default: state <= MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == MEM_WAIT) begin
      readData <= dmem[dataIndex];
    end
    if (state == MEM_DONE && memWrite && !ioSelect) begin
      dmem[dataIndex] <= dataIn;
    end
  end

  assign dataOut = readData;
  assign dataSuccess = (state == MEM_DONE) || (state == MEM_IDLE && !access);

  // I/O store bypasses RAM
  assign ioWrite = (state == MEM_DONE) && memWrite && ioSelect;
  assign ioData = dataIn;

endmodule

//--- verilog/Cpu.sv
`timescale 1ns/10ps

module Cpu import cpuPkg::*; (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          loadEnable,
  input  logic [$clog2(IMEM_WORDS)-1:0] loadAddress,
  input  logic [XLEN-1:0]               loadData,
  output logic                          ioWrite,
  output logic [XLEN-1:0]               ioData
);

  logic [XLEN-1:0] pc, ifInstruction, branchTarget;
  logic stall, freeze, dataSuccess, takeBranch;

  logic [XLEN-1:0] idInstruction, idPc, idImmediate, idRegA, idRegB;
  logic [REG_ADDR_W-1:0] idReadIndexA, idReadIndexB;
  aluOpT idAluOp;
  logic idAluSrc, idMemRead, idMemWrite, idMemToReg, idRegWrite;
  logic idBranch, idBranchNotEqual, idJump, idKill;

  logic [XLEN-1:0] exPc, exRegA, exRegB, exImmediate, exValueA, exValueB;
  logic [XLEN-1:0] aluA, aluB, aluResult;
  logic [REG_ADDR_W-1:0] exReadIndexA, exReadIndexB, exWriteIndex;
  logic [6:0] exOpcode, exFunct7;
  logic [2:0] exFunct3;
  logic [1:0] fwdA, fwdB;
  logic exAluSrc, exMemRead, exMemWrite, exMemToReg, exRegWrite;
  logic exBranch, exBranchNotEqual, exJump, aluZero;

  logic [XLEN-1:0] memAluResult, memStoreData, memReadData;
  logic [REG_ADDR_W-1:0] memWriteIndex;
  logic memMemRead, memMemWrite, memMemToReg, memRegWrite;

  logic [XLEN-1:0] wbAluResult, wbReadData, writeBackData;
  logic [REG_ADDR_W-1:0] wbWriteIndex;
  logic wbMemToReg, wbRegWrite;

  Mmu mmu(
    .clk(clk),
    .rstN(rstN),
    .loadEnable(loadEnable),
    .loadAddress(loadAddress),
    .loadData(loadData),
    .instrAddress(pc),
    .memRead(memMemRead),
    .memWrite(memMemWrite),
    .dataAddress(memAluResult),
    .dataIn(memStoreData),
    .instruction(ifInstruction),
    .dataOut(memReadData),
    .dataSuccess(dataSuccess),
    .ioWrite(ioWrite),
    .ioData(ioData)
  );

  // Whole pipeline holds while data memory is busy
  assign freeze = !dataSuccess;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else if (!freeze) begin
      if (takeBranch) begin
        pc <= branchTarget;
      end else if (!stall) begin
        pc <= pc + 32'd4;
      end
    end
  end

  // IF/ID
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idInstruction <= '0;
      idPc <= '0;
    end else if (!freeze) begin
      if (takeBranch) begin
        idInstruction <= '0;
      end else if (!stall) begin
        idInstruction <= ifInstruction;
        idPc <= pc;
      end
    end
  end

  Decoder decoder(
    .instruction(idInstruction),
    .aluOp(idAluOp),
    .aluSrc(idAluSrc),
    .memRead(idMemRead),
    .memWrite(idMemWrite),
    .memToReg(idMemToReg),
    .regWrite(idRegWrite),
    .branch(idBranch),
    .branchNotEqual(idBranchNotEqual),
    .jump(idJump),
    .immediate(idImmediate)
  );

  // LUI and JAL carry immediate bits where rs1 and rs2 would be
  assign idReadIndexA = (idAluOp != ALU_PASS_B && !idJump) ? idInstruction[19:15] : '0;
  assign idReadIndexB = (!idAluSrc || idMemWrite) ? idInstruction[24:20] : '0;

  RegisterFile registerFile(
    .clk(clk),
    .rstN(rstN),
    .readIndexA(idInstruction[19:15]),
    .readIndexB(idInstruction[24:20]),
    .writeIndex(wbWriteIndex),
    .writeData(writeBackData),
    .writeEnable(wbRegWrite),
    .readDataA(idRegA),
    .readDataB(idRegB)
  );

  HazardUnit hazardUnit(
    .idReadIndexA(idReadIndexA),
    .idReadIndexB(idReadIndexB),
    .exReadIndexA(exReadIndexA),
    .exReadIndexB(exReadIndexB),
    .exWriteIndex(exWriteIndex),
    .exMemRead(exMemRead),
    .memWriteIndex(memWriteIndex),
    .memRegWrite(memRegWrite),
    .wbWriteIndex(wbWriteIndex),
    .wbRegWrite(wbRegWrite),
    .stall(stall),
    .fwdA(fwdA),
    .fwdB(fwdB)
  );

  assign idKill = takeBranch || stall;

  // ID/EX control, bubble on flush or load-use stall
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMemRead <= 1'b0;
      exMemWrite <= 1'b0;
      exMemToReg <= 1'b0;
      exRegWrite <= 1'b0;
      exBranch <= 1'b0;
      exJump <= 1'b0;
      exReadIndexA <= '0;
      exReadIndexB <= '0;
      exWriteIndex <= '0;
    end else if (!freeze) begin
      exMemRead <= idMemRead && !idKill;
      exMemWrite <= idMemWrite && !idKill;
      exMemToReg <= idMemToReg && !idKill;
      exRegWrite <= idRegWrite && !idKill;
      exBranch <= idBranch && !idKill;
      exJump <= idJump && !idKill;
      exReadIndexA <= idReadIndexA;
      exReadIndexB <= idReadIndexB;
      exWriteIndex <= idInstruction[11:7];
    end
  end

  assign exValueA = (fwdA == 2'd2) ? memAluResult :
                    (fwdA == 2'd1) ? writeBackData : exRegA;
  assign exValueB = (fwdB == 2'd2) ? memAluResult :
                    (fwdB == 2'd1) ? writeBackData : exRegB;

  // JAL runs pc + 4 through the ALU for the link value
  assign aluA = exJump ? exPc : exValueA;
  assign aluB = exJump ? 32'd4 : (exAluSrc ? exImmediate : exValueB);

  Alu alu(
    .opcode(opcodeT'(exOpcode)),
    .funct3(exFunct3),
    .funct7(exFunct7),
    .operandA(aluA),
    .operandB(aluB),
    .result(aluResult),
    .zero(aluZero)
  );

  assign branchTarget = exPc + exImmediate;
  assign takeBranch = exJump || (exBranch && (aluZero != exBranchNotEqual));

  // EX/MEM and MEM/WB control
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memMemRead <= 1'b0;
      memMemWrite <= 1'b0;
      memMemToReg <= 1'b0;
      memRegWrite <= 1'b0;
      memWriteIndex <= '0;
      wbMemToReg <= 1'b0;
      wbRegWrite <= 1'b0;
      wbWriteIndex <= '0;
    end else if (!freeze) begin
      memMemRead <= exMemRead;
      memMemWrite <= exMemWrite;
      memMemToReg <= exMemToReg;
      memRegWrite <= exRegWrite;
      memWriteIndex <= exWriteIndex;
      wbMemToReg <= memMemToReg;
      wbRegWrite <= memRegWrite;
      wbWriteIndex <= memWriteIndex;
    end
  end

  // Barrier payload
  always_ff @(posedge clk) begin
    if (!freeze) begin
      exPc <= idPc;
      exRegA <= idRegA;
      exRegB <= idRegB;
      exImmediate <= idImmediate;
      exOpcode <= idInstruction[6:0];
      exFunct3 <= idInstruction[14:12];
      exFunct7 <= idInstruction[31:25];
      exAluSrc <= idAluSrc;
      exBranchNotEqual <= idBranchNotEqual;
      memAluResult <= aluResult;
      memStoreData <= exValueB;
      wbAluResult <= memAluResult;
      wbReadData <= memReadData;
    end
  end

  assign writeBackData = wbMemToReg ? wbReadData : wbAluResult;

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

endmodule

//--- testbench/tbCpu.sv
`timescale 1ns/10ps

module tbCpu import cpuPkg::*; ();

  localparam int LOAD_W = $clog2(IMEM_WORDS);
  localparam int CYCLES_PER_WORD = 30;
  localparam int QUIET_CYCLES = 20;

  logic clk;
  logic rstN;
  logic loadEnable;
  logic [LOAD_W-1:0] loadAddress;
  logic [XLEN-1:0] loadData;
  logic ioWrite;
  logic [XLEN-1:0] ioData;

  // Words of all cases packed into two queues
  string caseNames[$];
  int progStart[$];
  int progLen[$];
  int expStart[$];
  int expLen[$];
  logic [XLEN-1:0] progWords[$];
  logic [XLEN-1:0] expWords[$];

  int mismatchCount = 0;
  int missingCount = 0;
  int extraCount = 0;
  int otherCount = 0;
  int totalCycles = 0;
  int cycleLimit = 100000;

  clockGen clockSource (.clk(clk));

  Cpu u_Cpu (
    .clk(clk),
    .rstN(rstN),
    .loadEnable(loadEnable),
    .loadAddress(loadAddress),
    .loadData(loadData),
    .ioWrite(ioWrite),
    .ioData(ioData)
  );

  task automatic readCases(output bit ok);
    int fd;
    int code;
    int nWords;
    int nExp;
    string token;
    string rest;
    logic [XLEN-1:0] word;
    ok = 1'b0;
    fd = $fopen("testbench/cpuCases.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/cpuCases.txt");
      return;
    end
    while ($fscanf(fd, "%s", token) == 1) begin
      if (token[0] == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%d %d", nWords, nExp);
        if (code != 2) begin
          $display("Case %s has no word counts in the case file", token);
          $fclose(fd);
          return;
        end
        caseNames.push_back(token);
        progStart.push_back(progWords.size());
        progLen.push_back(nWords);
        expStart.push_back(expWords.size());
        expLen.push_back(nExp);
        for (int i = 0; i < nWords + nExp; i++) begin
          code = $fscanf(fd, "%h", word);
          if (code != 1) begin
            $display("Case %s is missing words in the case file", token);
            $fclose(fd);
            return;
          end
          if (i < nWords) begin
            progWords.push_back(word);
          end else begin
            expWords.push_back(word);
          end
        end
      end
    end
    $fclose(fd);
    ok = (caseNames.size() > 0);
  endtask

  task automatic runCase(input int c);
    int cycles;
    int got;
    int limit;
    logic [XLEN-1:0] expected;
    // Program goes in while reset is held
    @(posedge clk);
    rstN <= 1'b0;
    for (int i = 0; i < progLen[c]; i++) begin
      @(posedge clk);
      loadEnable <= 1'b1;
      loadAddress <= LOAD_W'(i);
      loadData <= progWords[progStart[c] + i];
    end
    @(posedge clk);
    loadEnable <= 1'b0;
    repeat (4) @(posedge clk);
    rstN <= 1'b1;

    cycles = 0;
    got = 0;
    limit = progLen[c] * CYCLES_PER_WORD;
    while (got < expLen[c] && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (ioWrite) begin
        expected = expWords[expStart[c] + got];
        if (ioData !== expected) begin
          $display("error %s: expected %h, actual %h", caseNames[c], expected, ioData);
          mismatchCount++;
        end
        got++;
      end
    end

    if (got < expLen[c]) begin
      $display("Case %s produced too few I/O writes, %0d of %0d within %0d cycles",
               caseNames[c], got, expLen[c], limit);
      missingCount++;
    end else begin
      // Nothing more may come out once the program sits in its final loop
      for (int i = 0; i < QUIET_CYCLES; i++) begin
        @(negedge clk);
        if (ioWrite) begin
          $display("Case %s made an unexpected I/O write of %h", caseNames[c], ioData);
          extraCount++;
        end
      end
    end
  endtask

  task automatic endRun();
    $display("cases %0d, value errors %0d, missing writes %0d, unexpected writes %0d, other %0d",
             caseNames.size(), mismatchCount, missingCount, extraCount, otherCount);
    if (mismatchCount + missingCount + extraCount + otherCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // ioWrite must stay quiet while reset is held
  initial begin
    forever begin
      @(negedge clk);
      if (!rstN && ioWrite) begin
        $display("ioWrite went high while reset was asserted");
        otherCount++;
      end
    end
  end

  initial begin
    while (totalCycles < cycleLimit) begin
      @(posedge clk);
      totalCycles++;
    end
    otherCount++;
    $display("Run stopped after %0d cycles without finishing the cases", totalCycles);
    endRun();
  end

  initial begin
    bit ok;
    int budget;
    rstN = 1'b0;
    loadEnable = 1'b0;
    loadAddress = '0;
    loadData = '0;
    readCases(ok);
    if (!ok) begin
      otherCount++;
      $display("No usable cases were read");
      endRun();
    end else begin
      budget = 0;
      foreach (progLen[c]) begin
        budget += progLen[c] * (CYCLES_PER_WORD + DMEM_WAIT + 1) + QUIET_CYCLES + 8;
      end
      cycleLimit = budget;
      foreach (caseNames[c]) begin
        runCase(c);
      end
      endRun();
    end
  end

endmodule

//--- vlog.f
verilog/cpuPkg.sv
verilog/Alu.sv
verilog/Decoder.sv
verilog/RegisterFile.sv
verilog/HazardUnit.sv
verilog/Mmu.sv
verilog/Cpu.sv
testbench/clockGen.sv
testbench/tbCpu.sv

//--- Bender.yml
package:
  name: pipelined_cpu

sources:
  - files:
      - verilog/cpuPkg.sv
      - verilog/Alu.sv
      - verilog/Decoder.sv
      - verilog/RegisterFile.sv
      - verilog/HazardUnit.sv
      - verilog/Mmu.sv
      - verilog/Cpu.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/tbCpu.sv

//--- testbench/cpuCases.txt
# name, instruction word count, expected write count (decimal)
# then the instruction words and the expected ioData values in order (hex)
reset_io 4 1
40000F93 00500093 001FA023 0000006F
00000005

alu_forward 22 9
40000F93 06400093 FE208113 002081B3 40310233 003272B3 0012E333 004343B3
00122433 0040A4B3 12345537 00750533 00AFA023 002FA023 003FA023 004FA023
005FA023 006FA023 007FA023 008FA023 009FA023 0000006F
12344F70 00000046 000000AA FFFFFF9C 00000088 000000EC FFFFFF70 00000001 00000000

mem_wait 15 3
40000F93 12300093 04000113 00112423 00812183 00118213 004FA023 00812283
005FA023 FFF00313 00612623 00C12383 00338433 008FA023 0000006F
00000124 00000123 00000122

branches 19 3
40000F93 00700093 00700113 00900193 00208663 003FA023 003FA023 00209663
01100213 004FA023 00308463 02200293 005FA023 00309663 003FA023 003FA023
03300313 006FA023 0000006F
00000011 00000022 00000033

jal_link 10 2
40000F93 00900193 00C000EF 003FA023 003FA023 001FA023 008002EF 003FA023
005FA023 0000006F
0000000C 0000001C
